/* hdl/epb_pkg.sv */
package epb_pkg;

  // host request as seen on the external bus pins
  // field order gives a 63-bit packed word
  typedef struct packed {
    // chip select, active low
    logic        cs_n;
    // high for a read
    logic        r_w_n;
    // byte enables, active low
    logic [3:0]  be_n;
    // word address, two lsbs are implied
    logic [24:0] addr;
    // write data, don't care on reads
    logic [31:0] wdata;
  } epb_req_t;

  // response back to the host
  // rdy pulses once per access
  typedef struct packed {
    // read data, valid with rdy
    logic [31:0] rdata;
    // one-cycle ready pulse
    logic        rdy;
    // error qualifier for rdy
    logic        err;
  } epb_rsp_t;

endpackage

/* hdl/opb_pkg.sv */
package opb_pkg;

  // address regions, bits 26:16 of the byte address
  localparam logic [10:0] region_reg = 11'd0;
  localparam logic [10:0] region_mem = 11'd1;

  // register bank indices
  localparam logic [1:0] reg_scratch0 = 2'd0;
  localparam logic [1:0] reg_scratch1 = 2'd1;
  localparam logic [1:0] reg_id       = 2'd2;
  localparam logic [1:0] reg_count    = 2'd3;

  // identifier register contents
  localparam logic [31:0] id_value = 32'h4550_4231;

  // cycles of unacknowledged select before the decoder gives up
  localparam logic [3:0] timeout_cycles = 4'd8;

  // single master drive
  typedef struct packed {
    logic        select;
    logic        rnw;
    logic [3:0]  be;
    logic [31:0] abus;
    logic [31:0] dbus;
  } opb_mst_t;

  // slave response, all zero when not selected so responses OR together
  typedef struct packed {
    logic [31:0] dbus;
    logic        xfer_ack;
    logic        err_ack;
    logic        timeout;
  } opb_slv_t;

  // register bank view of the byte address
  typedef struct packed {
    logic [4:0]  rsvd_hi;
    logic [10:0] region;
    logic [11:0] rsvd_lo;
    logic [1:0]  reg_idx;
    logic [1:0]  byte_off;
  } opb_reg_addr_t;

  // memory view of the byte address
  typedef struct packed {
    logic [4:0]  rsvd_hi;
    logic [10:0] region;
    logic [7:0]  rsvd_lo;
    logic [5:0]  word_idx;
    logic [1:0]  byte_off;
  } opb_mem_addr_t;

  // same 32-bit word, decoded per target
  typedef union packed {
    opb_reg_addr_t regs;
    opb_mem_addr_t mem;
  } opb_addr_u;

endpackage

/* hdl/epb_opb_bridge.sv */
`timescale 1ns/1ps

module epb_opb_bridge (
  input  logic              OPB_Clk,
  input  logic              rst_n,
  input  epb_pkg::epb_req_t epb_req,
  output epb_pkg::epb_rsp_t epb_rsp,
  output opb_pkg::opb_mst_t opb_mst,
  input  opb_pkg::opb_slv_t opb_slv
);

  // registered copy of chip select for edge detect
  logic        cs_n_q;
  logic        start;

  // captured request
  logic        rnw_q;
  logic [3:0]  be_q;
  logic [24:0] addr_q;
  logic [31:0] wdata_q;

  // bus and host control
  logic        select_q;
  logic        done;
  logic        rdy_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // falling chip select starts one transfer
  assign start = cs_n_q & ~epb_req.cs_n;

  // any of the three endings closes the transfer
  assign done = select_q & (opb_slv.xfer_ack | opb_slv.err_ack | opb_slv.timeout);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      cs_n_q <= 1'b1;
    end else begin
      cs_n_q <= epb_req.cs_n;
    end
  end

  // request fields latched on the edge, held for the whole transfer
  always_ff @(posedge OPB_Clk) begin
    if (start) begin
      rnw_q   <= epb_req.r_w_n;
      // enables flip to active high here
      be_q    <= ~epb_req.be_n;
      addr_q  <= epb_req.addr;
      wdata_q <= epb_req.wdata;
    end
  end

  // select rises the cycle after capture, drops after the ending ack
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      select_q <= 1'b0;
    end else if (done) begin
      select_q <= 1'b0;
    end else if (start) begin
      select_q <= 1'b1;
    end
  end

  // ready and error pulse for exactly one cycle
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      rdy_q <= done;
      err_q <= done & (opb_slv.err_ack | opb_slv.timeout);
    end
  end

  // read data held until the next access ends
  always_ff @(posedge OPB_Clk) begin
    if (done) begin
      rdata_q <= opb_slv.dbus;
    end
  end

  // word address to byte address, top bits zero
  assign opb_mst.select = select_q;
  assign opb_mst.rnw    = rnw_q;
  assign opb_mst.be     = be_q;
  assign opb_mst.abus   = {5'd0, addr_q, 2'b00};
  // write data bus quiet on reads
  assign opb_mst.dbus   = rnw_q ? 32'd0 : wdata_q;

  assign epb_rsp.rdata = rdata_q;
  assign epb_rsp.rdy   = rdy_q;
  assign epb_rsp.err   = err_q;

endmodule

/* hdl/opb_decoder.sv */
`timescale 1ns/1ps

module opb_decoder (
  input  logic              OPB_Clk,
  input  logic              rst_n,
  input  opb_pkg::opb_mst_t mst,
  output opb_pkg::opb_mst_t reg_mst,
  output opb_pkg::opb_mst_t mem_mst,
  input  opb_pkg::opb_slv_t reg_slv,
  input  opb_pkg::opb_slv_t mem_slv,
  output opb_pkg::opb_slv_t slv
);

  opb_pkg::opb_addr_u addr;
  logic               is_reg;
  logic               is_mem;
  logic               any_ack;
  logic               timeout;
  // cycles of select seen so far without an ack
  logic [3:0]         wait_cnt;

  assign addr = mst.abus;

  // region check through both address views
  assign is_reg = (addr.regs.region == opb_pkg::region_reg);
  assign is_mem = (addr.mem.region == opb_pkg::region_mem);

  // register bank sees select for every mapped access
  // its transfer counter needs memory traffic too
  // it still answers only its own region
  always_comb begin
    reg_mst        = mst;
    reg_mst.select = mst.select & (is_reg | is_mem);
    mem_mst        = mst;
    mem_mst.select = mst.select & is_mem;
  end

  assign any_ack = reg_slv.xfer_ack | reg_slv.err_ack |
                   mem_slv.xfer_ack | mem_slv.err_ack;

  // fires in the last allowed cycle of select
  assign timeout = mst.select & ~any_ack &
                   ((wait_cnt + 4'd1) == opb_pkg::timeout_cycles);

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      wait_cnt <= 4'd0;
    end else if (!mst.select || any_ack || timeout) begin
      // idle or transfer ended
      wait_cnt <= 4'd0;
    end else begin
      wait_cnt <= wait_cnt + 4'd1;
    end
  end

  // unselected slaves drive zero so a plain OR merges them
  always_comb begin
    slv.dbus     = reg_slv.dbus | mem_slv.dbus;
    slv.xfer_ack = reg_slv.xfer_ack | mem_slv.xfer_ack;
    slv.err_ack  = reg_slv.err_ack | mem_slv.err_ack;
    slv.timeout  = reg_slv.timeout | mem_slv.timeout | timeout;
  end

endmodule

/* hdl/opb_reg_slave.sv */
`timescale 1ns/1ps

module opb_reg_slave (
  input  logic              OPB_Clk,
  input  logic              rst_n,
  input  opb_pkg::opb_mst_t mst,
  output opb_pkg::opb_slv_t slv
);

  opb_pkg::opb_addr_u addr;
  logic               hit;
  logic               ro_reg;
  logic               wr_err;
  logic [31:0]        scratch0;
  logic [31:0]        scratch1;
  logic [31:0]        xfer_count;
  logic [31:0]        rd_word;
  // previous cycle select and error, for end-of-transfer detect
  logic               sel_q;
  logic               err_q;

  assign addr = mst.abus;

  // select arrives for memory accesses as well, so qualify by region
  assign hit = mst.select & (addr.regs.region == opb_pkg::region_reg);

  assign ro_reg = (addr.regs.reg_idx == opb_pkg::reg_id) |
                  (addr.regs.reg_idx == opb_pkg::reg_count);
  // writes to id or counter are refused
  assign wr_err = hit & ~mst.rnw & ro_reg;

  always_comb begin
    case (addr.regs.reg_idx)
      opb_pkg::reg_scratch0: rd_word = scratch0;
      opb_pkg::reg_scratch1: rd_word = scratch1;
      opb_pkg::reg_id:       rd_word = opb_pkg::id_value;
      default:               rd_word = xfer_count;
    endcase
  end

  // zero-wait response in the first select cycle
  always_comb begin
    slv.dbus     = (hit & mst.rnw) ? rd_word : 32'd0;
    slv.xfer_ack = hit & ~wr_err;
    slv.err_ack  = wr_err;
    slv.timeout  = 1'b0;
  end

  // byte-wise scratch writes
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      scratch0 <= 32'd0;
      scratch1 <= 32'd0;
    end else if (hit && !mst.rnw) begin
      for (int b = 0; b < 4; b++) begin
        if (mst.be[b] && addr.regs.reg_idx == opb_pkg::reg_scratch0) begin
          scratch0[8*b +: 8] <= mst.dbus[8*b +: 8];
        end
        if (mst.be[b] && addr.regs.reg_idx == opb_pkg::reg_scratch1) begin
          scratch1[8*b +: 8] <= mst.dbus[8*b +: 8];
        end
      end
    end
  end

  // select falling after a cycle with no err_ack means xfer_ack ended it
  // unmapped accesses never reach this select, so timeouts are not counted
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      sel_q      <= 1'b0;
      err_q      <= 1'b0;
      xfer_count <= 32'd0;
    end else begin
      sel_q <= mst.select;
      err_q <= slv.err_ack;
      if (sel_q && !mst.select && !err_q) begin
        xfer_count <= xfer_count + 32'd1;
      end
    end
  end

endmodule

/* hdl/opb_mem_slave.sv */
`timescale 1ns/1ps

module opb_mem_slave (
  input  logic              OPB_Clk,
  input  logic              rst_n,
  input  opb_pkg::opb_mst_t mst,
  output opb_pkg::opb_slv_t slv
);

  opb_pkg::opb_addr_u addr;
  logic [31:0]        mem [64];
  // set during the first select cycle
  logic               wait_q;
  logic               ack;
  logic [31:0]        rdata_q;

  assign addr = mst.abus;

  // ack lands in the second select cycle
  assign ack = mst.select & wait_q;

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else begin
      // one-shot, clears itself on the ack cycle
      wait_q <= mst.select & ~wait_q;
    end
  end

  // word fetched during the wait state
  always_ff @(posedge OPB_Clk) begin
    if (mst.select && !wait_q) begin
      rdata_q <= mem[addr.mem.word_idx];
    end
  end

  // contents start at zero, writes on the ack cycle only
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      for (int w = 0; w < 64; w++) begin
        mem[w] <= 32'd0;
      end
    end else if (ack && !mst.rnw) begin
      for (int b = 0; b < 4; b++) begin
        if (mst.be[b]) begin
          mem[addr.mem.word_idx][8*b +: 8] <= mst.dbus[8*b +: 8];
        end
      end
    end
  end

  // full word back on reads, enables ignored
  always_comb begin
    slv.dbus     = (ack & mst.rnw) ? rdata_q : 32'd0;
    slv.xfer_ack = ack;
    slv.err_ack  = 1'b0;
    slv.timeout  = 1'b0;
  end

endmodule

/* hdl/epb_opb_top.sv */
`timescale 1ns/1ps

module epb_opb_top (
  input  logic              OPB_Clk,
  input  logic              rst_n,
  input  epb_pkg::epb_req_t epb_req,
  output epb_pkg::epb_rsp_t epb_rsp
);

  // bridge drive and merged response
  opb_pkg::opb_mst_t opb_mst;
  opb_pkg::opb_slv_t opb_slv;

  // per-slave copies of the master drive
  opb_pkg::opb_mst_t reg_mst;
  opb_pkg::opb_mst_t mem_mst;

  // per-slave responses
  opb_pkg::opb_slv_t reg_slv;
  opb_pkg::opb_slv_t mem_slv;

  // host side, single master
  epb_opb_bridge i_epb_opb_bridge (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .epb_req (epb_req),
    .epb_rsp (epb_rsp),
    .opb_mst (opb_mst),
    .opb_slv (opb_slv)
  );

  // region decode and timeout
  opb_decoder i_opb_decoder (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .mst     (opb_mst),
    .reg_mst (reg_mst),
    .mem_mst (mem_mst),
    .reg_slv (reg_slv),
    .mem_slv (mem_slv),
    .slv     (opb_slv)
  );

  // region 0
  opb_reg_slave i_opb_reg_slave (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .mst     (reg_mst),
    .slv     (reg_slv)
  );

  // region 1
  opb_mem_slave i_opb_mem_slave (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .mst     (mem_mst),
    .slv     (mem_slv)
  );

endmodule

/* verification/epb_opb_properties.sv */
`timescale 1ns/1ps

module epb_opb_properties (
  input logic              OPB_Clk,
  input logic              rst_n,
  input opb_pkg::opb_mst_t opb_mst,
  input opb_pkg::opb_slv_t opb_slv,
  input epb_pkg::epb_rsp_t epb_rsp
);

  logic ending;

  // any of the three acks closes a transfer
  assign ending = opb_mst.select & (opb_slv.xfer_ack | opb_slv.err_ack | opb_slv.timeout);

  // select gone the cycle after the ending ack
  select_drops: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    ending |=> !opb_mst.select)
    else $error("select still high after an ending acknowledge");

  // no ack yet, so select and fields hold
  select_holds: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    opb_mst.select && !ending |=> opb_mst.select && $stable(opb_mst.abus) &&
    $stable(opb_mst.be) && $stable(opb_mst.rnw))
    else $error("select or transfer fields changed before an acknowledge");

  // ready is a single-cycle pulse
  rdy_single: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    epb_rsp.rdy |=> !epb_rsp.rdy)
    else $error("rdy high in two consecutive cycles");

endmodule

bind epb_opb_bridge epb_opb_properties i_epb_opb_properties (
  .OPB_Clk (OPB_Clk),
  .rst_n   (rst_n),
  .opb_mst (opb_mst),
  .opb_slv (opb_slv),
  .epb_rsp (epb_rsp)
);

/* verification/tb_epb_opb_top.sv */
`timescale 1ns/1ps

module tb_epb_opb_top;

  localparam int mem_ops = 16;
  localparam int mix_ops = 200;
  // memory pairs, scratch, id, unmapped, counter, random mix
  localparam int num_accesses = 2 * mem_ops + 6 + 3 + 2 + 1 + mix_ops;
  localparam int watchdog_cycles =
    num_accesses * (int'(opb_pkg::timeout_cycles) + 4) + 100;

  logic              OPB_Clk;
  logic              rst_n;
  epb_pkg::epb_req_t epb_req;
  epb_pkg::epb_rsp_t epb_rsp;

  // reference model state
  logic [31:0] mem_model [64];
  logic [31:0] scratch_model [2];
  // accesses that ended without error
  logic [31:0] ok_count;

  // expected and observed responses in access order
  string             name_q [$];
  logic              read_q [$];
  epb_pkg::epb_rsp_t exp_q [$];
  epb_pkg::epb_rsp_t act_q [$];
  // cycles from chip select low to rdy
  int                exp_lat_q [$];
  int                act_lat_q [$];

  int checks = 0;
  int errors = 0;

  epb_opb_top i_epb_opb_top (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .epb_req (epb_req),
    .epb_rsp (epb_rsp)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  // enables are active low on the host side
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be_n);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (!be_n[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return word;
  endfunction

  // expected response of one access, model updated as a side effect
  function automatic epb_pkg::epb_rsp_t ref_access(input logic rnw, input logic [24:0] addr,
                                                   input logic [3:0] be_n, input logic [31:0] wdata);
    epb_pkg::epb_rsp_t rsp;
    logic [5:0]        widx;
    rsp     = '0;
    rsp.rdy = 1'b1;
    widx    = addr[5:0];
    if (addr[24:14] == opb_pkg::region_mem) begin
      if (rnw) begin
        rsp.rdata = mem_model[widx];
      end else begin
        mem_model[widx] = merge_bytes(mem_model[widx], wdata, be_n);
      end
      ok_count++;
    end else if (addr[24:14] == opb_pkg::region_reg) begin
      case (addr[1:0])
        opb_pkg::reg_scratch0, opb_pkg::reg_scratch1: begin
          if (rnw) begin
            rsp.rdata = scratch_model[addr[0]];
          end else begin
            scratch_model[addr[0]] = merge_bytes(scratch_model[addr[0]], wdata, be_n);
          end
          ok_count++;
        end
        default: begin
          // id and counter are read-only
          if (!rnw) begin
            rsp.err = 1'b1;
          end else begin
            rsp.rdata = (addr[1:0] == opb_pkg::reg_id) ? opb_pkg::id_value : ok_count;
            ok_count++;
          end
        end
      endcase
    end else begin
      // unmapped, decoder timeout with zero data
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  // host latency set by whichever side ends the transfer
  function automatic int expected_latency(input logic [24:0] addr);
    if (addr[24:14] == opb_pkg::region_reg) begin
      return 2;
    end else if (addr[24:14] == opb_pkg::region_mem) begin
      return 3;
    end
    // unmapped ends on the decoder timeout
    return int'(opb_pkg::timeout_cycles) + 1;
  endfunction

  function automatic logic [24:0] reg_addr(input logic [1:0] idx);
    return {opb_pkg::region_reg, 12'd0, idx};
  endfunction

  // any region above the two mapped ones
  function automatic logic [24:0] unmapped_addr();
    logic [31:0] region;
    logic [31:0] low;
    region = $urandom_range(2, 2047);
    low    = $urandom;
    return {region[10:0], low[13:0]};
  endfunction

  // one host access, chip select held until rdy
  task automatic host_access(input string name, input logic rnw, input logic [24:0] addr,
                             input logic [3:0] be_n, input logic [31:0] wdata);
    epb_pkg::epb_rsp_t seen;
    int                cycles;
    @(negedge OPB_Clk);
    epb_req.cs_n  = 1'b0;
    epb_req.r_w_n = rnw;
    epb_req.be_n  = be_n;
    epb_req.addr  = addr;
    epb_req.wdata = wdata;
    name_q.push_back(name);
    read_q.push_back(rnw);
    exp_q.push_back(ref_access(rnw, addr, be_n, wdata));
    exp_lat_q.push_back(expected_latency(addr));
    @(negedge OPB_Clk);
    cycles = 1;
    while (!epb_rsp.rdy) begin
      @(negedge OPB_Clk);
      cycles++;
    end
    seen = epb_rsp;
    act_lat_q.push_back(cycles);
    act_q.push_back(seen);
    // high for at least one cycle before the next access
    epb_req.cs_n = 1'b1;
  endtask

  // mostly mapped traffic, unmapped ones are slow
  task automatic random_access();
    logic [31:0] rnd;
    logic [31:0] kind;
    logic [24:0] addr;
    rnd  = $urandom;
    kind = $urandom_range(0, 9);
    if (kind < 4) begin
      addr = {opb_pkg::region_reg, rnd[13:0]};
    end else if (kind < 9) begin
      addr = {opb_pkg::region_mem, rnd[13:0]};
    end else begin
      addr = unmapped_addr();
    end
    host_access("random", rnd[31], addr, rnd[30:27], $urandom);
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    logic [5:0]  idx [mem_ops];
    void'($urandom(65084));
    ok_count = '0;
    for (int w = 0; w < 64; w++) begin
      mem_model[w] = '0;
    end
    scratch_model[0] = '0;
    scratch_model[1] = '0;
    rst_n        = 1'b0;
    epb_req      = '0;
    epb_req.cs_n = 1'b1;
    repeat (3) @(posedge OPB_Clk);
    @(negedge OPB_Clk);
    rst_n = 1'b1;

    // random words under random enables, then read back
    for (int i = 0; i < mem_ops; i++) begin
      rnd    = $urandom;
      idx[i] = rnd[5:0];
      host_access("memory", 1'b0, {opb_pkg::region_mem, rnd[13:6], idx[i]}, rnd[31:28], $urandom);
    end
    for (int i = 0; i < mem_ops; i++) begin
      host_access("memory", 1'b1, {opb_pkg::region_mem, 8'd0, idx[i]}, 4'h0, 32'd0);
    end

    // full write, masked write, read back
    for (int r = 0; r < 2; r++) begin
      rnd = $urandom;
      host_access("scratch", 1'b0, reg_addr(r[1:0]), 4'h0, $urandom);
      host_access("scratch", 1'b0, reg_addr(r[1:0]), rnd[3:0], $urandom);
      host_access("scratch", 1'b1, reg_addr(r[1:0]), 4'h0, 32'd0);
    end

    host_access("identifier", 1'b1, reg_addr(opb_pkg::reg_id), 4'h0, 32'd0);
    host_access("identifier", 1'b0, reg_addr(opb_pkg::reg_id), 4'h0, $urandom);
    host_access("identifier", 1'b1, reg_addr(opb_pkg::reg_id), 4'h0, 32'd0);

    host_access("unmapped", 1'b1, unmapped_addr(), 4'h0, 32'd0);
    host_access("unmapped", 1'b0, unmapped_addr(), 4'h0, $urandom);

    host_access("counter", 1'b1, reg_addr(opb_pkg::reg_count), 4'h0, 32'd0);

    for (int i = 0; i < mix_ops; i++) begin
      random_access();
    end

    // compare process drains on the next edge
    repeat (2) @(posedge OPB_Clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // pushes land on falling edges, pops on rising edges
  initial begin : compare
    string             name;
    logic              is_read;
    epb_pkg::epb_rsp_t exp_rsp;
    epb_pkg::epb_rsp_t act_rsp;
    int                exp_lat;
    int                act_lat;
    forever begin
      @(posedge OPB_Clk);
      while (act_q.size() > 0) begin
        name    = name_q.pop_front();
        is_read = read_q.pop_front();
        exp_rsp = exp_q.pop_front();
        act_rsp = act_q.pop_front();
        exp_lat = exp_lat_q.pop_front();
        act_lat = act_lat_q.pop_front();
        checks++;
        assert (act_lat == exp_lat) else begin
          errors++;
          $display("Mismatch %s: latency expected %0d, actual %0d", name, exp_lat, act_lat);
        end
        checks++;
        assert (act_rsp.err === exp_rsp.err) else begin
          errors++;
          $display("Mismatch %s: err expected %0b, actual %0b", name, exp_rsp.err, act_rsp.err);
        end
        // read data only means something on reads
        if (is_read) begin
          checks++;
          assert (act_rsp.rdata === exp_rsp.rdata) else begin
            errors++;
            $display("Mismatch %s: rdata expected %h, actual %h", name, exp_rsp.rdata,
                     act_rsp.rdata);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge OPB_Clk);
    $display("watchdog expired after %0d cycles, a host access never completed",
             watchdog_cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* build.f */
hdl/epb_pkg.sv
hdl/opb_pkg.sv
hdl/epb_opb_bridge.sv
hdl/opb_decoder.sv
hdl/opb_reg_slave.sv
hdl/opb_mem_slave.sv
hdl/epb_opb_top.sv
verification/epb_opb_properties.sv
verification/tb_epb_opb_top.sv

/* Makefile */
TOP := tb_epb_opb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

# a crashed or stopped run counts as a failure too
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation finished: FAIL" >> sim.log
	cat sim.log
	! grep -q "Simulation finished: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
